/* common/retire_pkg.sv */
`default_nettype none

package retire_pkg;

    // rob tag width, depth may not exceed 2**tag_w
    localparam int tag_w = 4;

    localparam int reg_addr_w = 5;
    localparam int data_w = 32;
    localparam int addr_w = 32;

    // number of architectural registers
    localparam int num_regs = 2 ** reg_addr_w;

    // rob entry tag
    typedef logic [tag_w-1:0] tag_t;

    // occupancy count, one bit wider so a full rob is representable
    typedef logic [tag_w:0] count_t;

    typedef logic [reg_addr_w-1:0] reg_addr_t; // x0 never written
    typedef logic [data_w-1:0] data_t;
    typedef logic [addr_w-1:0] addr_t;          // redirect pc

    // selects the commit path of an entry
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_branch = 2'd1,
        op_store  = 2'd2
    } op_class_t;

endpackage

`default_nettype wire

/* rob/rob.sv */
`timescale 1ns/1ps
`default_nettype none

module rob #(
    parameter int depth = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  disp_valid,
    input  wire retire_pkg::op_class_t disp_op,
    input  wire retire_pkg::reg_addr_t disp_rd,
    input  wire logic                  disp_pred_taken,
    output logic                       disp_ready,
    output retire_pkg::tag_t           disp_tag,

    input  wire logic                  ex_valid,
    input  wire retire_pkg::tag_t      ex_tag,
    input  wire retire_pkg::data_t     ex_data,
    input  wire logic                  ex_taken,
    input  wire retire_pkg::addr_t     ex_target,

    input  wire logic                  sb_valid,
    input  wire retire_pkg::tag_t      sb_tag,

    output logic                       commit_valid,
    output retire_pkg::reg_addr_t      commit_rd,
    output retire_pkg::data_t          commit_data,
    output retire_pkg::tag_t           commit_tag,

    output logic                       store_commit_valid,
    output retire_pkg::tag_t           store_commit_tag,

    output logic                       flush,
    output retire_pkg::addr_t          redirect_pc
);
    import retire_pkg::*;

    // per-entry state
    logic      valid  [depth];
    logic      done   [depth];
    op_class_t op     [depth];
    reg_addr_t rd     [depth];
    data_t     data   [depth];
    logic      pred   [depth];
    logic      actual [depth];
    addr_t     target [depth];

    tag_t   head;
    tag_t   tail;
    tag_t   head_nxt;
    tag_t   tail_nxt;
    count_t count;

    logic full;
    logic alloc;
    logic retire;
    logic mispredict;

    assign head_nxt = (head == tag_t'(depth - 1)) ? '0 : head + 1'b1; // wrap at depth
    assign tail_nxt = (tail == tag_t'(depth - 1)) ? '0 : tail + 1'b1;

    assign full = (count == count_t'(depth));

    // no dispatch while the flush is visible
    assign disp_ready = !full && !flush;
    assign disp_tag = tail;
    assign alloc = disp_valid && disp_ready;

    assign retire = valid[head] && done[head];
    assign mispredict = retire && (op[head] == op_branch) && (pred[head] != actual[head]);

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            commit_valid <= 1'b0;
            store_commit_valid <= 1'b0;
            flush <= 1'b0;
            for (int i = 0; i < depth; i++) begin
                valid[i] <= 1'b0;
                done[i] <= 1'b0;
            end
        end else begin
            commit_valid <= 1'b0;
            store_commit_valid <= 1'b0;
            flush <= 1'b0;

            if (alloc) begin
                valid[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail <= tail_nxt;
            end

            // late writebacks of squashed entries are dropped
            if (ex_valid && !flush)
                done[ex_tag] <= 1'b1;
            if (sb_valid && !flush)
                done[sb_tag] <= 1'b1;

            if (retire) begin
                valid[head] <= 1'b0;
                done[head] <= 1'b0;
                head <= head_nxt;
                if (op[head] == op_store)
                    store_commit_valid <= 1'b1;
                else
                    commit_valid <= 1'b1; // branches commit too even when mispredicted
            end

            count <= count + count_t'(alloc) - count_t'(retire);

            // drop every entry younger than the branch
            if (mispredict) begin
                flush <= 1'b1;
                head <= '0;
                tail <= '0;
                count <= '0;
                for (int i = 0; i < depth; i++) begin
                    valid[i] <= 1'b0;
                    done[i] <= 1'b0;
                end
            end
        end
    end

    // entry payload and commit outputs
    always_ff @(posedge clk) begin
        if (alloc) begin
            op[tail] <= disp_op;
            rd[tail] <= disp_rd;
            pred[tail] <= disp_pred_taken;
        end

        if (ex_valid && !flush) begin
            data[ex_tag] <= ex_data;
            actual[ex_tag] <= ex_taken;
            target[ex_tag] <= ex_target;
        end

        if (retire) begin
            commit_rd <= rd[head];
            commit_data <= data[head];
            commit_tag <= head;
            store_commit_tag <= head;
        end

        if (mispredict)
            redirect_pc <= target[head];
    end

    // dispatch never lands on a live entry
    a_alloc_free: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !valid[tail]);

    // writebacks must name an in-flight entry that is not yet done
    a_ex_tag_live: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && !flush) |-> valid[ex_tag] && !done[ex_tag]);

    a_sb_tag_live: assert property (@(posedge clk) disable iff (rst)
        (sb_valid && !flush) |-> valid[sb_tag] && (op[sb_tag] == op_store));

    a_one_commit: assert property (@(posedge clk) disable iff (rst)
        !(commit_valid && store_commit_valid));

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  alloc_valid,
    input  wire retire_pkg::reg_addr_t alloc_rd,
    input  wire retire_pkg::tag_t      alloc_tag,

    input  wire logic                  commit_valid,
    input  wire retire_pkg::reg_addr_t commit_rd,
    input  wire retire_pkg::data_t     commit_data,
    input  wire retire_pkg::tag_t      commit_tag,

    input  wire logic                  flush,

    input  wire retire_pkg::reg_addr_t rs1_addr,
    input  wire retire_pkg::reg_addr_t rs2_addr,
    output retire_pkg::data_t          rs1_data,
    output retire_pkg::data_t          rs2_data,
    output logic                       rs1_busy,
    output logic                       rs2_busy,
    output retire_pkg::tag_t           rs1_tag,
    output retire_pkg::tag_t           rs2_tag
);
    import retire_pkg::*;

    data_t regs [num_regs];
    logic  busy [num_regs];
    tag_t  tags [num_regs]; // newest producer of each register

    // busy tracking
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++)
                busy[i] <= 1'b0;
        end else if (flush) begin
            for (int i = 0; i < num_regs; i++)
                busy[i] <= 1'b0;
        end else begin
            // only the newest producer frees the register
            if (commit_valid && (tags[commit_rd] == commit_tag))
                busy[commit_rd] <= 1'b0;
            if (alloc_valid && (alloc_rd != '0))
                busy[alloc_rd] <= 1'b1; // alloc wins over commit
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid && (alloc_rd != '0))
            tags[alloc_rd] <= alloc_tag;
        // data still lands during the flush cycle
        if (commit_valid && (commit_rd != '0))
            regs[commit_rd] <= commit_data;
    end

    // x0 reads zero and is never busy
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs1_busy = (rs1_addr != '0) && busy[rs1_addr];
    assign rs1_tag = tags[rs1_addr];

    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign rs2_busy = (rs2_addr != '0) && busy[rs2_addr];
    assign rs2_tag = tags[rs2_addr];

    // the rob only commits entries that target a real register
    a_no_x0_commit: assert property (@(posedge clk) disable iff (rst)
        commit_valid |-> (commit_rd != '0));

endmodule

`default_nettype wire

/* verilog/retire_top.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_top #(
    parameter int depth = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst,

    input  wire logic                  disp_valid,
    input  wire retire_pkg::op_class_t disp_op,
    input  wire retire_pkg::reg_addr_t disp_rd,
    input  wire logic                  disp_pred_taken,
    output logic                       disp_ready,
    output retire_pkg::tag_t           disp_tag,

    input  wire logic                  ex_valid,
    input  wire retire_pkg::tag_t      ex_tag,
    input  wire retire_pkg::data_t     ex_data,
    input  wire logic                  ex_taken,
    input  wire retire_pkg::addr_t     ex_target,

    input  wire logic                  sb_valid,
    input  wire retire_pkg::tag_t      sb_tag,

    output logic                       commit_valid,
    output retire_pkg::reg_addr_t      commit_rd,
    output retire_pkg::data_t          commit_data,
    output retire_pkg::tag_t           commit_tag,
    output logic                       store_commit_valid,
    output retire_pkg::tag_t           store_commit_tag,
    output logic                       flush,
    output retire_pkg::addr_t          redirect_pc,

    input  wire retire_pkg::reg_addr_t rs1_addr,
    input  wire retire_pkg::reg_addr_t rs2_addr,
    output retire_pkg::data_t          rs1_data,
    output retire_pkg::data_t          rs2_data,
    output logic                       rs1_busy,
    output logic                       rs2_busy,
    output retire_pkg::tag_t           rs1_tag,
    output retire_pkg::tag_t           rs2_tag
);
    import retire_pkg::*;

    logic alloc_valid;

    // rename only ops that write a real register
    assign alloc_valid = disp_valid && disp_ready && (disp_op != op_store) && (disp_rd != '0);

    rob #(
        .depth(depth)
    ) rob_inst (
        .clk(clk), .rst(rst),
        .disp_valid(disp_valid), .disp_op(disp_op), .disp_rd(disp_rd),
        .disp_pred_taken(disp_pred_taken), .disp_ready(disp_ready), .disp_tag(disp_tag),
        .ex_valid(ex_valid), .ex_tag(ex_tag), .ex_data(ex_data),
        .ex_taken(ex_taken), .ex_target(ex_target),
        .sb_valid(sb_valid), .sb_tag(sb_tag),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_tag(commit_tag),
        .store_commit_valid(store_commit_valid), .store_commit_tag(store_commit_tag),
        .flush(flush), .redirect_pc(redirect_pc)
    );

    reg_file reg_file_inst (
        .clk(clk), .rst(rst),
        .alloc_valid(alloc_valid), .alloc_rd(disp_rd), .alloc_tag(disp_tag),
        .commit_valid(commit_valid), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_tag(commit_tag),
        .flush(flush),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1_busy(rs1_busy), .rs2_busy(rs2_busy),
        .rs1_tag(rs1_tag), .rs2_tag(rs2_tag)
    );

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period = 40,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #5 rst = 1'b0; // released at the drive point
    end

endmodule

`default_nettype wire

/* tb/retire_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_tb;
    import retire_pkg::*;

    localparam int depth = 16;
    localparam int timeout = 100; // cycles per wait

    logic clk, rst;
    logic disp_valid, disp_pred_taken, disp_ready;
    op_class_t disp_op;
    reg_addr_t disp_rd, commit_rd, rs1_addr, rs2_addr;
    tag_t disp_tag, ex_tag, sb_tag, commit_tag, store_commit_tag, rs1_tag, rs2_tag;
    logic ex_valid, ex_taken, sb_valid, commit_valid, store_commit_valid, flush;
    logic rs1_busy, rs2_busy;
    data_t ex_data, commit_data, rs1_data, rs2_data;
    addr_t ex_target, redirect_pc;

    // reference model indexed by tag
    tag_t      pending [$]; // program order
    op_class_t m_op [depth];
    reg_addr_t m_rd [depth];
    data_t     m_data [depth];
    logic      m_pred [depth];
    logic      m_mispred [depth];
    addr_t     m_target [depth];
    data_t     arch [num_regs];
    tag_t      next_tag;
    int        errors;
    int        commits;

    tb_clock #(.period(40), .reset_cycles(8)) tb_clock_inst (.clk(clk), .rst(rst));

    retire_top #(.depth(depth)) retire_top_inst (.*);

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timed out at %0t waiting for %s", $time, what);
        $display("errors: %0d, commits checked: %0d", errors, commits);
        $display("=== FAIL ===");
        $finish;
    endtask

    // compare commit outputs with the oldest model entry each cycle
    task automatic observe_outputs();
        tag_t t;
        logic exp_flush;
        exp_flush = 1'b0;
        if (!rst && (commit_valid || store_commit_valid)) begin
            if (pending.size() == 0) begin
                $display("unexpected commit at %0t with nothing in flight", $time);
                errors++;
            end else begin
                t = pending.pop_front();
                commits++;
                if (commit_valid !== (m_op[t] != op_store))
                    report_mismatch("commit_valid", 32'(commit_valid), 32'(m_op[t] != op_store));
                if (commit_valid && commit_tag !== t)
                    report_mismatch("commit_tag", 32'(commit_tag), 32'(t));
                if (commit_valid && commit_rd !== m_rd[t])
                    report_mismatch("commit_rd", 32'(commit_rd), 32'(m_rd[t]));
                if (commit_valid && commit_data !== m_data[t])
                    report_mismatch("commit_data", commit_data, m_data[t]);
                if (store_commit_valid && store_commit_tag !== t)
                    report_mismatch("store_commit_tag", 32'(store_commit_tag), 32'(t));
                if (commit_valid)
                    arch[m_rd[t]] = m_data[t];
                exp_flush = m_mispred[t];
            end
        end
        if (!rst && flush !== exp_flush)
            report_mismatch("flush", 32'(flush), 32'(exp_flush));
        if (exp_flush) begin
            if (redirect_pc !== m_target[t])
                report_mismatch("redirect_pc", redirect_pc, m_target[t]);
            pending.delete(); // younger entries squashed
            next_tag = '0;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
        observe_outputs();
    endtask

    task automatic drive_dispatch(input op_class_t op, input reg_addr_t rd, input logic pred);
        disp_valid = 1'b1;
        disp_op = op;
        disp_rd = rd;
        disp_pred_taken = pred;
    endtask

    // hold until accepted and record in the model
    task automatic accept_dispatch(output tag_t tag);
        int waited;
        waited = 0;
        while (!disp_ready) begin
            waited++;
            if (waited > timeout)
                abort_on_timeout("disp_ready");
            next_cycle();
        end
        if (disp_tag !== next_tag)
            report_mismatch("disp_tag", 32'(disp_tag), 32'(next_tag));
        tag = next_tag;
        next_cycle();
        disp_valid = 1'b0;
        m_op[tag] = disp_op;
        m_rd[tag] = disp_rd;
        m_pred[tag] = disp_pred_taken;
        m_mispred[tag] = 1'b0;
        pending.push_back(tag);
        next_tag = tag_t'((int'(next_tag) + 1) % depth);
    endtask

    task automatic dispatch(input op_class_t op, input reg_addr_t rd, input logic pred,
                            output tag_t tag);
        drive_dispatch(op, rd, pred);
        accept_dispatch(tag);
    endtask

    task automatic writeback(input tag_t tag, input data_t data, input logic taken,
                             input addr_t target);
        ex_valid = 1'b1;
        ex_tag = tag;
        ex_data = data;
        ex_taken = taken;
        ex_target = target;
        m_data[tag] = data;
        m_target[tag] = target;
        m_mispred[tag] = (m_op[tag] == op_branch) && (taken != m_pred[tag]);
        next_cycle();
        ex_valid = 1'b0;
    endtask

    task automatic store_ready(input tag_t tag);
        sb_valid = 1'b1;
        sb_tag = tag;
        next_cycle();
        sb_valid = 1'b0;
    endtask

    // one more cycle so the register file takes the last write
    task automatic wait_commits(input int n);
        int waited;
        waited = 0;
        while (commits < n) begin
            waited++;
            if (waited > timeout)
                abort_on_timeout("commit");
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic check_reg(input reg_addr_t r, input logic exp_busy, input logic with_data);
        rs1_addr = r;
        rs2_addr = r;
        #1;
        if (rs1_busy !== exp_busy)
            report_mismatch("rs1_busy", 32'(rs1_busy), 32'(exp_busy));
        if (rs2_busy !== exp_busy)
            report_mismatch("rs2_busy", 32'(rs2_busy), 32'(exp_busy));
        if (with_data && rs1_data !== arch[r])
            report_mismatch("rs1_data", rs1_data, arch[r]);
        if (with_data && rs2_data !== arch[r])
            report_mismatch("rs2_data", rs2_data, arch[r]);
        next_cycle();
    endtask

    task automatic check_idle_regs();
        for (int i = 0; i < num_regs; i++)
            check_reg(reg_addr_t'(i), 1'b0, 1'b0);
    endtask

    task automatic test_reset();
        if (disp_ready !== 1'b1)
            report_mismatch("disp_ready", 32'(disp_ready), 1);
        if (disp_tag !== '0)
            report_mismatch("disp_tag", 32'(disp_tag), 0);
        if ({commit_valid, store_commit_valid, flush} !== 3'b000)
            report_mismatch("{commit_valid, store_commit_valid, flush}",
                            32'({commit_valid, store_commit_valid, flush}), 0);
        check_idle_regs();
    endtask

    task automatic test_in_order();
        tag_t t [4];
        int base;
        base = commits;
        for (int i = 0; i < 4; i++)
            dispatch(op_alu, reg_addr_t'(i + 1), 1'b0, t[i]);
        for (int i = 3; i >= 0; i--)
            writeback(t[i], $urandom, 1'b0, '0); // youngest first
        wait_commits(base + 4);
        for (int i = 1; i <= 4; i++)
            check_reg(reg_addr_t'(i), 1'b0, 1'b1);
    endtask

    task automatic test_renaming();
        tag_t older, younger;
        int base;
        base = commits;
        dispatch(op_alu, 5'd5, 1'b0, older);
        dispatch(op_alu, 5'd5, 1'b0, younger);
        writeback(older, $urandom, 1'b0, '0);
        wait_commits(base + 1);
        check_reg(5'd5, 1'b1, 1'b1); // older value with the younger producer pending
        if (rs1_tag !== younger)
            report_mismatch("rs1_tag", 32'(rs1_tag), 32'(younger));
        if (rs2_tag !== younger)
            report_mismatch("rs2_tag", 32'(rs2_tag), 32'(younger));
        writeback(younger, $urandom, 1'b0, '0);
        wait_commits(base + 2);
        check_reg(5'd5, 1'b0, 1'b1);
    endtask

    task automatic test_store();
        tag_t st;
        int base;
        base = commits;
        dispatch(op_store, 5'd1, 1'b0, st);
        repeat (4)
            next_cycle();
        if (commits != base) begin
            $display("store retired at %0t before the store buffer was ready", $time);
            errors++;
        end
        store_ready(st);
        wait_commits(base + 1);
        check_reg(5'd1, 1'b0, 1'b1); // untouched by the store
    endtask

    task automatic test_full();
        tag_t tags [depth + 1];
        int base;
        base = commits;
        for (int i = 0; i < depth; i++)
            dispatch(op_alu, reg_addr_t'(16 + i % 8), 1'b0, tags[i]);
        drive_dispatch(op_alu, 5'd24, 1'b0);
        repeat (3) begin
            if (disp_ready !== 1'b0)
                report_mismatch("disp_ready", 32'(disp_ready), 0);
            next_cycle();
        end
        writeback(tags[0], $urandom, 1'b0, '0);
        accept_dispatch(tags[depth]); // lands on the wrapped tag
        for (int i = 1; i <= depth; i++)
            writeback(tags[i], $urandom, 1'b0, '0);
        wait_commits(base + depth + 1);
    endtask

    task automatic test_flush();
        tag_t br, a, b;
        addr_t tgt;
        int base;
        base = commits;
        tgt = $urandom & 32'hffff_fffc;
        dispatch(op_branch, 5'd10, 1'b0, br);
        dispatch(op_alu, 5'd11, 1'b0, a);
        dispatch(op_alu, 5'd12, 1'b0, b);
        writeback(b, $urandom, 1'b0, '0);
        writeback(a, $urandom, 1'b0, '0);
        writeback(br, $urandom, 1'b1, tgt); // predicted not taken
        wait_commits(base + 1);
        repeat (4)
            next_cycle();
        check_reg(5'd10, 1'b0, 1'b1);
        check_idle_regs();
        dispatch(op_branch, 5'd13, 1'b1, br);
        dispatch(op_alu, 5'd14, 1'b0, a);
        writeback(br, $urandom, 1'b1, tgt + 32'd8);
        writeback(a, $urandom, 1'b0, '0);
        wait_commits(base + 3);
    endtask

    initial begin
        int waited;
        errors = 0;
        commits = 0;
        next_tag = '0;
        void'($urandom(32'h39c0));
        disp_valid = 1'b0;
        disp_op = op_alu;
        disp_rd = '0;
        disp_pred_taken = 1'b0;
        ex_valid = 1'b0;
        ex_tag = '0;
        ex_data = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        sb_valid = 1'b0;
        sb_tag = '0;
        rs1_addr = '0;
        rs2_addr = '0;
        waited = 0;
        while (rst !== 1'b0) begin
            waited++;
            if (waited > timeout)
                abort_on_timeout("reset release");
            next_cycle();
        end
        test_reset();
        test_in_order();
        test_renaming();
        test_store();
        test_full();
        test_flush();
        $display("errors: %0d, commits checked: %0d", errors, commits);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* retire_top.f */
common/retire_pkg.sv
rob/rob.sv
verilog/reg_file.sv
verilog/retire_top.sv
tb/tb_clock.sv
tb/retire_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := retire_tb
FILELIST := retire_top.f
BIN      := obj_dir/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
